//--- build.f
+incdir+.
design/video_pkg.sv
design/host_pkg.sv
design/sync_decimator.sv
design/ycbcr_to_rgb565.sv
design/fb_writer.sv
design/frame_ram.sv
design/host_port.sv
design/capture_top.sv
tb/capture_asserts.sv
tb/capture_tb.sv

//--- Makefile
# Verilator build and run of the capture testbench

.PHONY: all run lint clean

all: run

obj_dir/Vcapture_tb: build.f capture_config.svh $(wildcard design/*.sv tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module capture_tb -f build.f

# pass only if the testbench printed its pass line
run: obj_dir/Vcapture_tb
	@out="$$(./obj_dir/Vcapture_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

lint:
	verilator --lint-only -Wall --timing --top-module capture_tb -f build.f

clean:
	rm -rf obj_dir

//--- tb/capture_tb.sv
/*
 Testbench for the video capture front end.
 Drives odd and even fields of decoder bytes, predicts every frame
 buffer word with a model of the decimation and colour rules, and
 reads both banks back through the host port. Also checks the field
 end interrupts and host reads that overlap live capture.
*/
`timescale 1ns/1ps
`include "capture_config.svh"

module capture_tb;
	localparam int LINE_BYTES  = 64;                // short lines, 8 pixels each
	localparam int LINE_GAP    = 16;                // href low between lines
	localparam int FIELD_LINES = 7;
	localparam int FIELD_GAP   = 48;                // vref low / settle time
	localparam int FIELD_BYTES = FIELD_LINES * (LINE_BYTES + LINE_GAP) + 2 * FIELD_GAP;
	localparam int N_FIELDS    = 3;
	localparam int WATCHDOG_NS = N_FIELDS * FIELD_BYTES * 8 * 4;
	localparam int READ_LIMIT  = 32;                // cycles a read may wait
	localparam int ADR_W       = `CAP_BANK_ADR_W;

	logic                    clk_llc;
	logic                    resetx;
	logic                    vref;
	logic                    href;
	logic                    odd;
	logic [`CAP_BYTE_W-1:0]  vpo;
	logic                    host_cs_n;
	logic                    host_rd_n;
	logic [ADR_W:0]          host_adr;
	logic [`CAP_WORD_W-1:0]  host_data;
	logic                    host_waitx;
	logic                    irq0;
	logic                    irq1;

	video_pkg::rgb565_t exp_mem [2][64];            // predicted bank contents
	int                 exp_cnt [2];
	logic               line_tgl;                   // model of the line toggle
	logic               model_bank;
	int                 errors;
	int                 tests_done;
	int                 tests_bad;

	capture_top i_dut (
		.clk_llc    (clk_llc),
		.resetx     (resetx),
		.vref       (vref),
		.href       (href),
		.odd        (odd),
		.vpo        (vpo),
		.host_cs_n  (host_cs_n),
		.host_rd_n  (host_rd_n),
		.host_adr   (host_adr),
		.host_data  (host_data),
		.host_waitx (host_waitx),
		.irq0       (irq0),
		.irq1       (irq1)
	);

	initial
	begin
		clk_llc = 1'b0;
		forever #4 clk_llc = ~clk_llc;              // 8 ns period
	end

	// hard stop, four times the nominal stimulus length
	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("RESULT: FAIL");
		$finish;
	end

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------

	// 6-bit field from bits 17:12, clamped both ways
	function automatic int clamp_field6(input int s);
		if (s < 0)
			return 0;
		else if (s >= (1 << 18))
			return 63;
		else
			return (s >> 12) & 63;
	endfunction

	function automatic video_pkg::rgb565_t ref_rgb565(input int y, input int cb, input int cr);
		int                 yy;
		int                 u;
		int                 v;
		int                 d0;
		int                 d1;
		video_pkg::rgb565_t p;
		yy = 4 * y - `CSC_Y_OFFSET;                 // 10-bit scale
		u  = 4 * cb - `CSC_C_OFFSET;
		v  = 4 * cr - `CSC_C_OFFSET;
		d0 = (y - `KEY0_Y) ** 2 + (cb - `KEY0_CB) ** 2 + (cr - `KEY0_CR) ** 2;
		d1 = (y - `KEY1_Y) ** 2 + (cb - `KEY1_CB) ** 2 + (cr - `KEY1_CR) ** 2;
		if (y < `DARK_Y_LIMIT)
			p = '0;                                 // black wins over keys
		else if (d0 < `KEY_RADIUS_SQ || d1 < `KEY_RADIUS_SQ)
			p = '1;
		else
		begin
			p.r = 5'(clamp_field6(yy * `CSC_K_Y + v * `CSC_K_RV) >> 1);
			p.g = 6'(clamp_field6(yy * `CSC_K_Y - v * `CSC_K_GV - u * `CSC_K_GU));
			p.b = 5'(clamp_field6(yy * `CSC_K_Y + u * `CSC_K_BU) >> 1);
		end
		return p;
	endfunction

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------
	task automatic check_pixel(input logic [ADR_W:0] adr, input video_pkg::rgb565_t exp,
		input video_pkg::rgb565_t got);
		if (got !== exp)
		begin
			errors++;
			$display("error host_data at %h: expected %h got %h", adr, exp, got);
		end
	endtask

	task automatic expect_level(input string name, input logic exp, input logic got);
		if (got !== exp)
		begin
			errors++;
			$display("error %s: expected %h got %h", name, exp, got);
		end
	endtask

	// waits for the field end pulse, then checks the line and its length
	task automatic check_irq(input logic bank, input int max_cycles);
		int   n;
		logic got;
		n = 0;
		while (!irq0 && !irq1 && n < max_cycles)
		begin
			@(negedge clk_llc);
			n++;
		end
		if (!irq0 && !irq1)
		begin
			errors++;
			$display("no field end interrupt within %0d cycles", max_cycles);
			return;
		end
		got = irq0;                                 // irq0 names bank 1
		if (got !== bank)
		begin
			errors++;
			$display("error irq bank: expected %h got %h", bank, got);
		end
		n = 0;
		while (irq0 || irq1)
		begin
			if (irq0 && irq1)
			begin
				errors++;
				$display("irq0 and irq1 were high in the same cycle");
			end
			n++;
			@(negedge clk_llc);
		end
		if (n != `IRQ_PULSE_CYCLES)
		begin
			errors++;
			$display("interrupt pulse lasted %0d cycles instead of %0d", n, `IRQ_PULSE_CYCLES);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_done++;
		if (errors == err_before)
			$display("test %0d %s: ok", tests_done, name);
		else
		begin
			tests_bad++;
			$display("test %0d %s: %0d errors", tests_done, name, errors - err_before);
		end
	endtask

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------

	// one href line of random bytes, fixed mode plants dark and keyed groups
	task automatic put_line(input logic cap_field, input bit fixed);
		logic [`CAP_BYTE_W-1:0] b [LINE_BYTES];
		video_pkg::rgb565_t     e;
		int                     i;
		int                     g;
		for (i = 0; i < LINE_BYTES; i++)
			b[i] = 8'($urandom);
		for (g = 0; fixed && g < LINE_BYTES / `CAP_GROUP_BYTES; g++)
		begin
			i = g * `CAP_GROUP_BYTES;
			// key colours sit below the dark limit so Y is lifted into the radius
			case (g % 4)
				1: b[i+1] = 8'($urandom % `DARK_Y_LIMIT);
				2:
				begin
					b[i]   = 8'(`KEY0_CB);
					b[i+1] = 8'(`KEY0_Y + 40);
					b[i+2] = 8'(`KEY0_CR);
				end
				3:
				begin
					b[i]   = 8'(`KEY1_CB);
					b[i+1] = 8'(`KEY1_Y + 60);
					b[i+2] = 8'(`KEY1_CR);
				end
				default: ;
			endcase
		end
		line_tgl = ~line_tgl;                       // flips on every href rise
		for (i = 0; i < LINE_BYTES; i++)
		begin
			@(posedge clk_llc);
			href <= 1'b1;
			vpo  <= b[i];
		end
		@(posedge clk_llc);
		href <= 1'b0;
		repeat (LINE_GAP - 1) @(posedge clk_llc);
		for (g = 0; cap_field && line_tgl && g < LINE_BYTES / `CAP_GROUP_BYTES; g++)
		begin
			i = g * `CAP_GROUP_BYTES;
			e = ref_rgb565(b[i+1], b[i], b[i+2]);   // Cb, Y, Cr order
			if (fixed && g % 4 == 1)
				e = '0;
			else if (fixed && g % 4 >= 2)
				e = '1;
			exp_mem[model_bank][exp_cnt[model_bank]] = e;
			exp_cnt[model_bank]++;
		end
	endtask

	task automatic run_field(input logic odd_v, input bit fixed);
		int n;
		@(posedge clk_llc);
		vref <= 1'b1;
		odd  <= odd_v;
		repeat (FIELD_GAP - 1) @(posedge clk_llc);
		for (n = 0; n < FIELD_LINES; n++)
			put_line(odd_v, fixed);
		@(posedge clk_llc);
		vref <= 1'b0;                               // ends the field
		repeat (FIELD_GAP - 1) @(posedge clk_llc);
		if (odd_v)
			model_bank = ~model_bank;
	endtask

	// ------------------------------------------------------------
	// host side
	// ------------------------------------------------------------
	task automatic host_read(input logic [ADR_W:0] adr, output logic [`CAP_WORD_W-1:0] data);
		int n;
		@(posedge clk_llc);
		host_cs_n <= 1'b0;
		host_rd_n <= 1'b0;
		host_adr  <= adr;
		@(negedge clk_llc);
		if (host_waitx)
		begin
			errors++;
			$display("host_waitx stayed high in the first cycle of the read at %h", adr);
		end
		n = 0;
		while (!host_waitx && n < READ_LIMIT)
		begin
			@(negedge clk_llc);
			n++;
		end
		if (!host_waitx)
		begin
			errors++;
			$display("read at %h never released host_waitx", adr);
		end
		data = host_data;                           // sampled with wait released
		@(posedge clk_llc);
		host_cs_n <= 1'b1;
		host_rd_n <= 1'b1;
		@(posedge clk_llc);
	endtask

	task automatic read_bank(input logic bank);
		logic [`CAP_WORD_W-1:0] d;
		int                     a;
		if (exp_cnt[bank] == 0)
		begin
			errors++;
			$display("no pixels were predicted for bank %0d", bank);
		end
		for (a = 0; a < exp_cnt[bank]; a++)
		begin
			host_read({bank, ADR_W'(a)}, d);
			check_pixel({bank, ADR_W'(a)}, exp_mem[bank][a], d);
		end
	endtask

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial
	begin
		int e0;
		resetx     = 1'b0;
		vref       = 1'b0;
		href       = 1'b0;
		odd        = 1'b0;
		vpo        = '0;
		host_cs_n  = 1'b1;
		host_rd_n  = 1'b1;
		host_adr   = '0;
		errors     = 0;
		tests_done = 0;
		tests_bad  = 0;
		line_tgl   = 1'b0;
		model_bank = 1'b0;
		exp_cnt[0] = 0;
		exp_cnt[1] = 0;
		void'($urandom(32'h0ba9_0ba6));
		repeat (8) @(posedge clk_llc);
		resetx <= 1'b1;

		e0 = errors;
		@(negedge clk_llc);
		expect_level("irq0", 1'b0, irq0);
		expect_level("irq1", 1'b0, irq1);
		expect_level("host_waitx", 1'b1, host_waitx);
		report_test("reset state", e0);

		e0 = errors;
		fork
			run_field(1'b1, 1'b0);
			check_irq(1'b0, FIELD_BYTES + LINE_GAP);
		join
		report_test("odd field, irq1 names bank 0", e0);

		e0 = errors;
		read_bank(1'b0);
		report_test("bank 0 readback", e0);

		// host reads bank 0 while bank 1 fills
		e0 = errors;
		fork
			run_field(1'b1, 1'b1);
			check_irq(1'b1, FIELD_BYTES + LINE_GAP);
			begin
				repeat (FIELD_GAP + LINE_BYTES) @(posedge clk_llc);
				read_bank(1'b0);
			end
		join
		report_test("reads during capture, irq0 names bank 1", e0);

		e0 = errors;
		read_bank(1'b1);
		report_test("bank 1 dark and keyed pixels", e0);

		// bank 0 is the write bank again here
		e0 = errors;
		run_field(1'b0, 1'b0);
		read_bank(1'b0);
		report_test("even field leaves bank 0", e0);

		$display("tests %0d, failed %0d, errors %0d", tests_done, tests_bad, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- tb/capture_asserts.sv
/*
 Concurrent checks on the interrupt lines and the host wait line.
 Bound into capture_top by the bind at the end of this file, so it
 also sees the frame_active and wr_valid wires inside the top level.
*/
`timescale 1ns/1ps

module capture_asserts (
	input logic clk_llc,
	input logic resetx,
	input logic frame_active,
	input logic irq0,
	input logic irq1,
	input logic wr_valid,
	input logic host_waitx
);
	// ------------------------------------------------------------
	// interrupts, started by the field end, two cycles each
	// ------------------------------------------------------------
	irq_at_field_end: assert property (@(posedge clk_llc) disable iff (!resetx)
		$rose(irq0 || irq1) |-> $past(frame_active, 2) && !$past(frame_active))
		else $error("interrupt not started by the end of a field");

	irq0_width: assert property (@(posedge clk_llc) disable iff (!resetx)
		$rose(irq0) |=> irq0 ##1 !irq0) else $error("irq0 pulse not two cycles");

	irq1_width: assert property (@(posedge clk_llc) disable iff (!resetx)
		$rose(irq1) |=> irq1 ##1 !irq1) else $error("irq1 pulse not two cycles");

	// read with a free RAM in its first cycle, wait low for exactly two
	wait_exact: assert property (@(posedge clk_llc) disable iff (!resetx)
		$fell(host_waitx) && !wr_valid |=> !host_waitx ##1 host_waitx)
		else $error("host_waitx not released two cycles after a free RAM cycle");

endmodule

bind capture_top capture_asserts i_asserts (
	.clk_llc      (clk_llc),
	.resetx       (resetx),
	.frame_active (frame_active),
	.irq0         (irq0),
	.irq1         (irq1),
	.wr_valid     (wr_valid),
	.host_waitx   (host_waitx)
);

//--- design/capture_top.sv
/*
 Top level of the video capture front end.
 Decoder bytes go through decimation, colour conversion and the
 frame buffer writer; the host reads words through the host port.
 Instances and connecting wires only.
*/
`timescale 1ns/1ps
`include "capture_config.svh"

module capture_top (
	input  logic                      clk_llc,
	input  logic                      resetx,
	input  logic                      vref,
	input  logic                      href,
	input  logic                      odd,
	input  logic [`CAP_BYTE_W-1:0]    vpo,
	input  logic                      host_cs_n,
	input  logic                      host_rd_n,
	input  logic [`CAP_BANK_ADR_W:0]  host_adr,
	output logic [`CAP_WORD_W-1:0]    host_data,
	output logic                      host_waitx,
	output logic                      irq0,
	output logic                      irq1
);
	// ------------------------------------------------------------
	// pixel path
	// ------------------------------------------------------------
	logic                  sample_valid;
	video_pkg::ycbcr_t     sample;
	logic                  field_end;
	logic                  frame_active;
	logic                  pix_valid;
	video_pkg::rgb565_t    pix;
	logic                  wr_valid;
	video_pkg::fb_write_t  wr;

	// host and RAM side
	host_pkg::host_req_t    req;
	host_pkg::fb_access_t   ram_acc;
	logic [`CAP_WORD_W-1:0] ram_q;

	assign req = '{cs_n: host_cs_n, rd_n: host_rd_n, adr: host_adr};

	sync_decimator i_sync (
		.clk_llc      (clk_llc),
		.resetx       (resetx),
		.vref         (vref),
		.href         (href),
		.odd          (odd),
		.vpo          (vpo),
		.sample_valid (sample_valid),
		.sample       (sample),
		.field_end    (field_end),
		.frame_active (frame_active)
	);

	ycbcr_to_rgb565 i_csc (
		.clk_llc      (clk_llc),
		.resetx       (resetx),
		.sample_valid (sample_valid),
		.sample       (sample),
		.pix_valid    (pix_valid),
		.pix          (pix)
	);

	fb_writer i_writer (
		.clk_llc      (clk_llc),
		.resetx       (resetx),
		.pix_valid    (pix_valid),
		.pix          (pix),
		.frame_active (frame_active),
		.field_end    (field_end),
		.wr_valid     (wr_valid),
		.wr           (wr),
		.irq0         (irq0),
		.irq1         (irq1)
	);

	host_port i_host (
		.clk_llc    (clk_llc),
		.resetx     (resetx),
		.wr_valid   (wr_valid),
		.wr         (wr),
		.req        (req),
		.ram_q      (ram_q),
		.ram_acc    (ram_acc),
		.host_data  (host_data),
		.host_waitx (host_waitx)
	);

	frame_ram i_ram (
		.clk_llc (clk_llc),
		.acc     (ram_acc),
		.q       (ram_q)
	);

endmodule

//--- design/host_port.sv
/*
 Host read port of the frame buffer.
 Video writes always own the RAM in their cycle, a pending host read
 takes the next free cycle. host_waitx is held low until the word is
 in the hold register, which then stays valid until rd_n rises.
*/
`timescale 1ns/1ps
`include "capture_config.svh"

module host_port (
	input  logic                    clk_llc,
	input  logic                    resetx,
	input  logic                    wr_valid,
	input  video_pkg::fb_write_t    wr,
	input  host_pkg::host_req_t     req,
	input  logic [`CAP_WORD_W-1:0]  ram_q,
	output host_pkg::fb_access_t    ram_acc,
	output logic [`CAP_WORD_W-1:0]  host_data,
	output logic                    host_waitx
);
	typedef enum logic [1:0] {
		RD_IDLE,                       // nothing issued
		RD_ISSUED,                     // ram_q valid this cycle
		RD_DONE                        // word held, wait released
	} rd_state_t;

	rd_state_t rd_st;
	logic      rd_req;
	logic      rd_go;                  // read gets the RAM now

	assign rd_req = ~req.cs_n & ~req.rd_n;
	assign rd_go  = rd_req & ~wr_valid & (rd_st == RD_IDLE);

	// ------------------------------------------------------------
	// RAM grant, writer first
	// ------------------------------------------------------------
	always_comb
	begin
		ram_acc.en    = wr_valid | rd_go;
		ram_acc.we    = wr_valid;
		ram_acc.adr   = wr_valid ? wr.adr : req.adr;
		ram_acc.wdata = wr.pix;
	end

	// read tracking
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			rd_st <= RD_IDLE;
		else
		begin
			case (rd_st)
				RD_IDLE:
				begin
					if (rd_go)
						rd_st <= RD_ISSUED;
				end
				RD_ISSUED: rd_st <= RD_DONE;
				RD_DONE:
				begin
					if (!rd_req)
						rd_st <= RD_IDLE;   // rd_n released
				end
				default: rd_st <= RD_IDLE;
			endcase
		end
	end

	// hold register
	always_ff @(posedge clk_llc)
	begin
		if (rd_st == RD_ISSUED)
			host_data <= ram_q;
	end

	// low from first request cycle until data held
	assign host_waitx = ~(rd_req & (rd_st != RD_DONE));

endmodule

//--- design/frame_ram.sv
/*
 Two-bank frame buffer memory, one access port.
 Bank selected by the address msb, one bank holds a full field.
 Read data is registered and stays put until the next read.
*/
`timescale 1ns/1ps
`include "capture_config.svh"

module frame_ram (
	input  logic                    clk_llc,
	input  host_pkg::fb_access_t    acc,
	output logic [`CAP_WORD_W-1:0]  q
);
	localparam int DEPTH = `CAP_LINE_PIXELS * `CAP_LINES;  // rest of bank unused

	logic [`CAP_WORD_W-1:0] mem [2][DEPTH];
	logic                   bank;
	logic [`CAP_BANK_ADR_W-1:0] wadr;

	assign bank = acc.adr[`CAP_BANK_ADR_W];
	assign wadr = acc.adr[`CAP_BANK_ADR_W-1:0];

	always_ff @(posedge clk_llc)
	begin
		if (acc.en)
		begin
			if (acc.we)
				mem[bank][wadr] <= acc.wdata;
			else
				q <= mem[bank][wadr];  // registered read
		end
	end

endmodule

//--- design/fb_writer.sv
/*
 Frame buffer write side.
 Gives each converted pixel the next word address in the current bank,
 pulses the interrupt of the bank just filled at field end and then
 swaps banks for the next field.
*/
`timescale 1ns/1ps
`include "capture_config.svh"

module fb_writer (
	input  logic                  clk_llc,
	input  logic                  resetx,
	input  logic                  pix_valid,
	input  video_pkg::rgb565_t    pix,
	input  logic                  frame_active,
	input  logic                  field_end,
	output logic                  wr_valid,
	output video_pkg::fb_write_t  wr,
	output logic                  irq0,           // bank 1 filled
	output logic                  irq1            // bank 0 filled
);
	localparam int IRQ_W = $clog2(`IRQ_PULSE_CYCLES + 1);

	logic [`CAP_BANK_ADR_W-1:0] wadr;
	logic                       bank;
	logic [IRQ_W-1:0]           irq_cnt;
	logic                       irq_on;

	// ------------------------------------------------------------
	// address counter and write strobe
	// ------------------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			wadr     <= '0;
			wr_valid <= 1'b0;
		end
		else
		begin
			wr_valid <= pix_valid;
			if (!frame_active)
				wadr <= '0;            // rewind between fields
			else if (pix_valid)
				wadr <= wadr + 1'b1;
		end
	end

	always_ff @(posedge clk_llc)
	begin
		if (pix_valid)
			wr <= '{adr: {bank, wadr}, pix: pix};
	end

	// ------------------------------------------------------------
	// field end interrupt, bank swap after the pulse
	// ------------------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			irq_cnt <= '0;
			bank    <= 1'b0;
		end
		else if (field_end)
			irq_cnt <= IRQ_W'(`IRQ_PULSE_CYCLES);
		else if (irq_on)
		begin
			irq_cnt <= irq_cnt - 1'b1;
			if (irq_cnt == IRQ_W'(1))
				bank <= ~bank;         // last pulse cycle
		end
	end

	assign irq_on = (irq_cnt != '0);
	assign irq0   = irq_on & bank;
	assign irq1   = irq_on & ~bank;

endmodule

//--- design/ycbcr_to_rgb565.sv
/*
 Fixed point YCbCr to rgb565 conversion, two pipeline stages.
 Stage 1 removes offsets, forms the products and the dark and key tests.
 Stage 2 sums, clamps and applies black or white overrides.
 pix_valid follows sample_valid by exactly two cycles.
*/
`timescale 1ns/1ps
`include "capture_config.svh"

module ycbcr_to_rgb565 (
	input  logic                clk_llc,
	input  logic                resetx,
	input  logic                sample_valid,
	input  video_pkg::ycbcr_t   sample,
	output logic                pix_valid,
	output video_pkg::rgb565_t  pix
);
	logic signed [10:0] y_d, cb_d, cr_d;           // 10-bit scale, offsets removed
	logic signed [21:0] p_y, p_rv, p_gv, p_gu, p_bu;
	logic               s1_valid;
	logic               dark_s1;
	logic               key_s1;
	logic signed [23:0] sum_r, sum_g, sum_b;
	logic [5:0]         r_f, g_f, b_f;

	// squared distance to a key colour at 8-bit scale
	function automatic logic [17:0] dist_sq(
		input logic [7:0] y, cb, cr,
		input logic [7:0] ky, kcb, kcr
	);
		logic signed [8:0] dy, db, dr;
		logic [17:0]       sy, sb, sr;
		dy = $signed({1'b0, ky}) - $signed({1'b0, y});
		db = $signed({1'b0, kcb}) - $signed({1'b0, cb});
		dr = $signed({1'b0, kcr}) - $signed({1'b0, cr});
		sy = dy * dy;
		sb = db * db;
		sr = dr * dr;
		return sy + sb + sr;
	endfunction

	// negative -> 0, past bit 17 -> all ones
	function automatic logic [5:0] clamp6(input logic signed [23:0] s);
		if (s[23])
			return '0;
		else if (s[22:18] != '0)
			return '1;
		else
			return s[17:12];
	endfunction

	assign y_d  = $signed({1'b0, sample.y, 2'b00}) - $signed(11'(`CSC_Y_OFFSET));
	assign cb_d = $signed({1'b0, sample.cb, 2'b00}) - $signed(11'(`CSC_C_OFFSET));
	assign cr_d = $signed({1'b0, sample.cr, 2'b00}) - $signed(11'(`CSC_C_OFFSET));

	// ------------------------------------------------------------
	// stage 1, products and tests
	// ------------------------------------------------------------
	always_ff @(posedge clk_llc)
	begin
		if (sample_valid)
		begin
			p_y  <= y_d  * $signed({1'b0, 10'(`CSC_K_Y)});
			p_rv <= cr_d * $signed({1'b0, 10'(`CSC_K_RV)});
			p_gv <= cr_d * $signed({1'b0, 10'(`CSC_K_GV)});
			p_gu <= cb_d * $signed({1'b0, 10'(`CSC_K_GU)});
			p_bu <= cb_d * $signed({1'b0, 10'(`CSC_K_BU)});
			dark_s1 <= sample.y < 8'(`DARK_Y_LIMIT);
			key_s1  <= (dist_sq(sample.y, sample.cb, sample.cr,
				8'(`KEY0_Y), 8'(`KEY0_CB), 8'(`KEY0_CR)) < 18'(`KEY_RADIUS_SQ))
				|| (dist_sq(sample.y, sample.cb, sample.cr,
				8'(`KEY1_Y), 8'(`KEY1_CB), 8'(`KEY1_CR)) < 18'(`KEY_RADIUS_SQ));
		end
	end

	// ------------------------------------------------------------
	// stage 2, sums, clamp, overrides
	// ------------------------------------------------------------
	always_comb
	begin
		sum_r = p_y + p_rv;
		sum_g = p_y - p_gv - p_gu;
		sum_b = p_y + p_bu;
		r_f   = clamp6(sum_r);
		g_f   = clamp6(sum_g);
		b_f   = clamp6(sum_b);
	end

	always_ff @(posedge clk_llc)
	begin
		if (s1_valid)
		begin
			if (dark_s1)
				pix <= '0;             // black
			else if (key_s1)
				pix <= '1;             // white
			else
				pix <= '{r: r_f[5:1], g: g_f, b: b_f[5:1]};  // r,b from 17:13
		end
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			s1_valid  <= 1'b0;
			pix_valid <= 1'b0;
		end
		else
		begin
			s1_valid  <= sample_valid;
			pix_valid <= s1_valid;
		end
	end

endmodule

//--- design/sync_decimator.sv
/*
 Field and line decimation of the decoder byte stream.
 Keeps odd fields, every other line and one pixel per byte group,
 and latches Cb, Y and Cr into one sample with a one-cycle strobe.
 Also flags the end of each captured field.
*/
`timescale 1ns/1ps
`include "capture_config.svh"

module sync_decimator (
	input  logic                    clk_llc,
	input  logic                    resetx,
	input  logic                    vref,           // vertical sync
	input  logic                    href,           // horizontal sync
	input  logic                    odd,            // odd field
	input  logic [`CAP_BYTE_W-1:0]  vpo,            // decoder byte
	output logic                    sample_valid,
	output video_pkg::ycbcr_t       sample,
	output logic                    field_end,
	output logic                    frame_active
);
	localparam int PH_W = $clog2(`CAP_GROUP_BYTES);

	logic            act;           // odd field with vref
	logic            act_q;
	logic            href_q;
	logic            href_rise;
	logic            line_tgl;      // every other line
	logic            line_cap;      // toggle value after this byte's flip
	logic            byte_en;       // byte belongs to a kept line
	logic [PH_W-1:0] ph;            // byte phase in group

	assign act       = odd & vref;
	assign href_rise = href & ~href_q;
	assign line_cap  = href_rise ? ~line_tgl : line_tgl;
	assign byte_en   = href & act & line_cap;

	// ------------------------------------------------------------
	// sync edges, line toggle, byte phase
	// ------------------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			href_q   <= 1'b0;
			line_tgl <= 1'b0;          // first line kept
			act_q    <= 1'b0;
			ph       <= '0;
		end
		else
		begin
			href_q <= href;
			act_q  <= act;
			if (href_rise)
				line_tgl <= ~line_tgl;
			if (byte_en)
				ph <= ph + 1'b1;       // wraps at group size
			else
				ph <= '0;
		end
	end

	// strobes
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			sample_valid <= 1'b0;
			field_end    <= 1'b0;
		end
		else
		begin
			sample_valid <= byte_en && (ph == PH_W'(2));  // after Cr
			field_end    <= act_q & ~act;                 // active -> inactive
		end
	end

	// byte latches, bytes 3..7 dropped
	always_ff @(posedge clk_llc)
	begin
		if (byte_en)
		begin
			case (ph)
				PH_W'(0): sample.cb <= vpo;
				PH_W'(1): sample.y  <= vpo;
				PH_W'(2): sample.cr <= vpo;
				default: ;
			endcase
		end
	end

	assign frame_active = act_q;

endmodule

//--- design/host_pkg.sv
/*
 Types for the host side of the frame buffer.
 The sampled host strobes and address, and the single access
 port that the host port drives into the frame RAM.
*/
`include "capture_config.svh"

package host_pkg;

	// host pins, strobes active low
	typedef struct packed {
		logic                     cs_n;
		logic                     rd_n;
		logic [`CAP_BANK_ADR_W:0] adr;   // bank bit + word address
	} host_req_t;

	// one RAM access per cycle, write or read
	typedef struct packed {
		logic                     en;
		logic                     we;
		logic [`CAP_BANK_ADR_W:0] adr;
		logic [`CAP_WORD_W-1:0]   wdata;
	} fb_access_t;

endpackage

//--- design/video_pkg.sv
/*
 Types carried along the pixel path of the capture front end.
 A decimated YCbCr sample, the converted rgb565 pixel and the
 frame buffer write that the writer hands to the host port.
*/
`include "capture_config.svh"

package video_pkg;

	// ------------------------------------------------------------
	// capture side samples
	// ------------------------------------------------------------

	// one kept pixel, bytes as latched from the decoder
	typedef struct packed {
		logic [`CAP_BYTE_W-1:0] y;
		logic [`CAP_BYTE_W-1:0] cb;
		logic [`CAP_BYTE_W-1:0] cr;
	} ycbcr_t;

	// host side pixel format, r in the top bits
	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	// ------------------------------------------------------------
	// frame buffer write
	// ------------------------------------------------------------

	// adr msb is the bank, lower bits the word inside the bank
	typedef struct packed {
		logic [`CAP_BANK_ADR_W:0] adr;
		rgb565_t                  pix;
	} fb_write_t;

endpackage

//--- capture_config.svh
/*
 Shared constants for the video capture front end.
 Covers bus widths, bank geometry, colour conversion coefficients,
 key colours and the interrupt pulse length.
 Include it in any file that uses one of these macros.
*/
`ifndef CAPTURE_CONFIG_SVH
`define CAPTURE_CONFIG_SVH

// ------------------------------------------------------------
// widths and geometry
// ------------------------------------------------------------
`define CAP_BYTE_W          8       // decoder byte
`define CAP_WORD_W          16      // frame buffer word, rgb565
`define CAP_BANK_ADR_W      15      // word address inside one bank
`define CAP_LINE_PIXELS     180     // kept pixels per line
`define CAP_LINES           120     // kept lines per bank
`define CAP_GROUP_BYTES     8       // bytes per kept pixel

// ------------------------------------------------------------
// colour conversion, unsigned Q2.8
// ------------------------------------------------------------
`define CSC_K_Y             298     // 1.164
`define CSC_K_RV            408     // 1.596
`define CSC_K_GV            208     // 0.813
`define CSC_K_GU            100     // 0.392
`define CSC_K_BU            516     // 2.017
`define CSC_Y_OFFSET        64      // 16 at 10-bit scale
`define CSC_C_OFFSET        512     // 128 at 10-bit scale

// dark pixels and colour keys
`define DARK_Y_LIMIT        80
`define KEY0_Y              77
`define KEY0_CB             84
`define KEY0_CR             249
`define KEY1_Y              35
`define KEY1_CB             255
`define KEY1_CR             130
`define KEY_RADIUS_SQ       16384

`define IRQ_PULSE_CYCLES    2       // field end interrupt length

`endif
